// File: logic/axi_lite_pkg.sv
package axi_lite_pkg;

   // bus-side widths
   typedef logic [31:0] axi_addr_t;
   typedef logic [31:0] axi_data_t;
   typedef logic [3:0]  axi_strb_t;

   // 16-byte peripheral window
   localparam axi_addr_t UART_BASE_ADDR = 32'h2000_0000;
   localparam axi_addr_t UART_ADDR_MASK = 32'h0000_000F; // offset bits inside window

   // write captured when aw and w handshake together
   typedef struct packed {
      axi_addr_t awaddr;
      axi_data_t wdata;
      axi_strb_t wstrb;
   } axi_wr_req_t;

   typedef struct packed {
      axi_addr_t araddr;
   } axi_rd_req_t;

endpackage

// File: logic/uart_pkg.sv
package uart_pkg;

   // register map
   typedef logic [3:0] reg_off_t;
   localparam reg_off_t REG_CTRL   = 4'h0;
   localparam reg_off_t REG_STATUS = 4'h4;
   localparam reg_off_t REG_RDATA  = 4'h8; // read only, pops rx fifo
   localparam reg_off_t REG_WDATA  = 4'hC; // write only, pushes tx fifo

   typedef logic [7:0]  uart_byte_t;
   typedef logic [15:0] baud_div_t; // clock cycles per bit

   localparam baud_div_t BAUD_DIV_MIN = 16'd4;
   localparam int        FRAME_BITS   = 10; // start + 8 data + stop

   typedef struct packed {
      baud_div_t   baud_div;
      logic [13:0] rsvd;
      logic        rx_en;
      logic        tx_en;
   } uart_ctrl_t;

   // reset value 4'b1010, both fifos empty
   typedef struct packed {
      logic rx_empty;
      logic rx_full;
      logic tx_empty;
      logic tx_full;
   } uart_status_t;

   localparam int FIFO_DEPTH = 16;
   typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
   typedef logic [$clog2(FIFO_DEPTH):0]   fifo_cnt_t; // 0..16

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   // very small dividers would break mid-bit sampling
   function automatic baud_div_t baud_clamp(input baud_div_t div);
      return (div < BAUD_DIV_MIN) ? BAUD_DIV_MIN : div;
   endfunction

endpackage

// File: logic/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo
   import uart_pkg::*;
(
   input  logic       s_axi_aclk_i,
   input  logic       s_axi_aresetn_i,
   input  logic       push_i,
   input  uart_byte_t data_i,
   input  logic       pop_i,
   output uart_byte_t data_o,
   output logic       full_o,
   output logic       empty_o
);

   uart_byte_t mem_q [FIFO_DEPTH];
   fifo_ptr_t  wr_ptr_q;
   fifo_ptr_t  rd_ptr_q;
   fifo_cnt_t  count_q;
   fifo_cnt_t  count_nxt;
   logic       full_q;
   logic       empty_q;
   logic       do_push;
   logic       do_pop;

   assign do_push = push_i && !full_q;  // overflow guard
   assign do_pop  = pop_i && !empty_q;  // underflow guard
   assign data_o  = mem_q[rd_ptr_q];    // head entry
   assign full_o  = full_q;
   assign empty_o = empty_q;

   always_comb begin
      count_nxt = count_q;
      if (do_push && !do_pop)
         count_nxt = count_q + 1'b1;
      else if (do_pop && !do_push)
         count_nxt = count_q - 1'b1;
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // pointers wrap at depth
         if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_nxt;
         full_q  <= (count_nxt == fifo_cnt_t'(FIFO_DEPTH));
         empty_q <= (count_nxt == '0);
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (do_push) mem_q[wr_ptr_q] <= data_i;
   end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
(
   input  logic       s_axi_aclk_i,
   input  logic       s_axi_aresetn_i,
   input  logic       enable_i,
   input  baud_div_t  baud_div_i,
   input  logic       fifo_empty_i,
   input  uart_byte_t fifo_data_i,
   output logic       fifo_pop_o,
   output logic       txd_o
);

   baud_div_t             div;
   baud_div_t             baud_cnt_q;
   logic [3:0]            bit_idx_q;   // 0 = start, 9 = stop
   logic [FRAME_BITS-1:0] shift_q;
   logic                  busy_q;
   logic                  baud_tick;
   logic                  frame_end;
   logic                  start;

   assign div       = baud_clamp(baud_div_i);
   assign baud_tick = busy_q && (baud_cnt_q == div - 1'b1);
   assign frame_end = baud_tick && (bit_idx_q == 4'(FRAME_BITS - 1));

   // a new frame may follow the stop bit with no idle gap
   assign start      = enable_i && !fifo_empty_i && (!busy_q || frame_end);
   assign fifo_pop_o = start;
   assign txd_o      = shift_q[0];

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         busy_q     <= 1'b0;
         baud_cnt_q <= '0;
         bit_idx_q  <= '0;
         shift_q    <= '1; // line idles high
      end else if (start) begin
         busy_q     <= 1'b1;
         baud_cnt_q <= '0;
         bit_idx_q  <= '0;
         shift_q    <= {1'b1, fifo_data_i, 1'b0};
      end else if (baud_tick) begin
         baud_cnt_q <= '0;
         bit_idx_q  <= bit_idx_q + 1'b1;
         shift_q    <= {1'b1, shift_q[FRAME_BITS-1:1]}; // lsb first, fill with idle
         if (frame_end)
            busy_q <= 1'b0; // enable only checked between frames
      end else if (busy_q) begin
         baud_cnt_q <= baud_cnt_q + 1'b1;
      end
   end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
(
   input  logic       s_axi_aclk_i,
   input  logic       s_axi_aresetn_i,
   input  logic       enable_i,
   input  baud_div_t  baud_div_i,
   input  logic       rxd_i,
   input  logic       fifo_full_i,
   output logic       fifo_push_o,
   output uart_byte_t fifo_data_o
);

   baud_div_t  div;
   baud_div_t  half;
   baud_div_t  baud_cnt_q;
   logic [2:0] sync_q;    // two sync stages plus one for edge detect
   logic       line;
   logic       fall;
   rx_state_t  state_q;
   logic [2:0] bit_idx_q;
   uart_byte_t shift_q;
   logic       half_tick;
   logic       bit_tick;

   assign div       = baud_clamp(baud_div_i);
   assign half      = div >> 1;
   assign line      = sync_q[1];
   assign fall      = sync_q[2] && !sync_q[1];
   assign half_tick = (baud_cnt_q == half - 1'b1);
   assign bit_tick  = (baud_cnt_q == div - 1'b1);

   // bad stop bit or full fifo loses the byte
   assign fifo_push_o = (state_q == RX_STOP) && bit_tick && line && !fifo_full_i;
   assign fifo_data_o = shift_q;

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         sync_q     <= '1;
         state_q    <= RX_IDLE;
         baud_cnt_q <= '0;
         bit_idx_q  <= '0;
      end else begin
         sync_q <= {sync_q[1:0], rxd_i};
         if (!enable_i) begin
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
         end else begin
            case (state_q)
               RX_IDLE: begin
                  baud_cnt_q <= '0;
                  if (fall) state_q <= RX_START;
               end
               RX_START: begin
                  if (half_tick) begin
                     baud_cnt_q <= '0;
                     bit_idx_q  <= '0;
                     state_q    <= line ? RX_IDLE : RX_DATA; // glitch, not a start bit
                  end else begin
                     baud_cnt_q <= baud_cnt_q + 1'b1;
                  end
               end
               RX_DATA: begin
                  if (bit_tick) begin
                     baud_cnt_q <= '0;
                     bit_idx_q  <= bit_idx_q + 1'b1;
                     if (bit_idx_q == 3'd7) state_q <= RX_STOP;
                  end else begin
                     baud_cnt_q <= baud_cnt_q + 1'b1;
                  end
               end
               RX_STOP: begin
                  if (bit_tick) begin
                     baud_cnt_q <= '0;
                     state_q    <= RX_IDLE;
                  end else begin
                     baud_cnt_q <= baud_cnt_q + 1'b1;
                  end
               end
               default: state_q <= RX_IDLE;
            endcase
         end
      end
   end

   // mid-bit samples, lsb arrives first
   always_ff @(posedge s_axi_aclk_i) begin
      if (state_q == RX_DATA && bit_tick) shift_q <= {line, shift_q[7:1]};
   end

endmodule

// File: logic/axi_uart_regs.sv
`timescale 1ns/1ps

module axi_uart_regs
   import axi_lite_pkg::*;
   import uart_pkg::*;
(
   input  logic         s_axi_aclk_i,
   input  logic         s_axi_aresetn_i,
   input  logic         wr_valid_i,
   input  axi_wr_req_t  wr_req_i,
   output logic         wr_ready_o,
   output logic         bvalid_o,
   input  logic         bready_i,
   input  logic         rd_valid_i,
   input  axi_rd_req_t  rd_req_i,
   output logic         rd_ready_o,
   output axi_data_t    rdata_o,
   output logic         rvalid_o,
   input  logic         rready_i,
   output uart_ctrl_t   ctrl_o,
   input  uart_status_t status_i,
   input  uart_byte_t   rx_byte_i,
   output logic         rx_pop_o,
   output uart_byte_t   tx_byte_o,
   output logic         tx_push_o
);

   uart_ctrl_t ctrl_q;
   uart_ctrl_t ctrl_nxt;
   axi_data_t  rdata_q;
   axi_data_t  rdata_nxt;
   logic       port_en_q; // ready rises one cycle after reset
   logic       bvalid_q;
   logic       rvalid_q;
   logic       wr_fire;
   logic       rd_fire;
   logic       wr_in_win;
   logic       rd_in_win;
   reg_off_t   wr_off;
   reg_off_t   rd_off;

   assign wr_in_win = (wr_req_i.awaddr & ~UART_ADDR_MASK) == UART_BASE_ADDR;
   assign rd_in_win = (rd_req_i.araddr & ~UART_ADDR_MASK) == UART_BASE_ADDR;
   assign wr_off    = reg_off_t'(wr_req_i.awaddr & UART_ADDR_MASK);
   assign rd_off    = reg_off_t'(rd_req_i.araddr & UART_ADDR_MASK);

   // no new request while a response waits
   assign wr_ready_o = port_en_q && !bvalid_q;
   assign rd_ready_o = port_en_q && !rvalid_q;
   assign wr_fire    = wr_valid_i && wr_ready_o;
   assign rd_fire    = rd_valid_i && rd_ready_o;

   assign bvalid_o = bvalid_q;
   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;
   assign ctrl_o   = ctrl_q;

   assign rx_pop_o  = rd_fire && rd_in_win && (rd_off == REG_RDATA) && !status_i.rx_empty;
   assign tx_push_o = wr_fire && wr_in_win && (wr_off == REG_WDATA) && wr_req_i.wstrb[0]
                      && !status_i.tx_full; // dropped when full
   assign tx_byte_o = wr_req_i.wdata[7:0];

   // byte lanes of CTRL follow wstrb
   always_comb begin
      ctrl_nxt = ctrl_q;
      for (int i = 0; i < 4; i++) begin
         if (wr_req_i.wstrb[i]) ctrl_nxt[8*i +: 8] = wr_req_i.wdata[8*i +: 8];
      end
      ctrl_nxt.rsvd = '0; // reserved reads as zero
   end

   always_comb begin
      rdata_nxt = '0;
      if (rd_in_win) begin
         case (rd_off)
            REG_CTRL:   rdata_nxt = ctrl_q;
            REG_STATUS: rdata_nxt = axi_data_t'(status_i);
            REG_RDATA:  if (!status_i.rx_empty) rdata_nxt = axi_data_t'(rx_byte_i);
            default:    rdata_nxt = '0; // WDATA is write only
         endcase
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         port_en_q <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
         ctrl_q    <= '0;
      end else begin
         port_en_q <= 1'b1;
         if (wr_fire)
            bvalid_q <= 1'b1;
         else if (bready_i)
            bvalid_q <= 1'b0;
         if (rd_fire)
            rvalid_q <= 1'b1;
         else if (rready_i)
            rvalid_q <= 1'b0;
         if (wr_fire && wr_in_win && wr_off == REG_CTRL) ctrl_q <= ctrl_nxt;
      end
   end

   // held until rready, since no read is accepted meanwhile
   always_ff @(posedge s_axi_aclk_i) begin
      if (rd_fire) rdata_q <= rdata_nxt;
   end

endmodule

// File: logic/axi_uart.sv
`timescale 1ns/1ps

module axi_uart
   import axi_lite_pkg::*;
   import uart_pkg::*;
(
   input  logic      s_axi_aclk_i,
   input  logic      s_axi_aresetn_i,
   input  axi_addr_t s_axi_awaddr_i,
   input  logic      s_axi_awvalid_i,
   output logic      s_axi_awready_o,
   input  axi_data_t s_axi_wdata_i,
   input  axi_strb_t s_axi_wstrb_i,
   input  logic      s_axi_wvalid_i,
   output logic      s_axi_wready_o,
   output logic      s_axi_bvalid_o,
   input  logic      s_axi_bready_i,
   input  axi_addr_t s_axi_araddr_i,
   input  logic      s_axi_arvalid_i,
   output logic      s_axi_arready_o,
   output axi_data_t s_axi_rdata_o,
   output logic      s_axi_rvalid_o,
   input  logic      s_axi_rready_i,
   output logic      uart_txd_o,
   input  logic      uart_rxd_i
);

   axi_wr_req_t  wr_req;
   axi_rd_req_t  rd_req;
   logic         wr_ready;
   uart_ctrl_t   ctrl;
   uart_status_t status;
   uart_byte_t   tx_byte, tx_head, rx_byte, rx_head;
   logic         tx_push, tx_pop, tx_full, tx_empty;
   logic         rx_push, rx_pop, rx_full, rx_empty;

   // aw and w are taken together
   assign wr_req          = '{awaddr: s_axi_awaddr_i, wdata: s_axi_wdata_i, wstrb: s_axi_wstrb_i};
   assign rd_req          = '{araddr: s_axi_araddr_i};
   assign s_axi_awready_o = wr_ready;
   assign s_axi_wready_o  = wr_ready;
   assign status          = '{rx_empty: rx_empty, rx_full: rx_full,
                              tx_empty: tx_empty, tx_full: tx_full};

   axi_uart_regs regs0 (
      .s_axi_aclk_i, .s_axi_aresetn_i,
      .wr_valid_i (s_axi_awvalid_i && s_axi_wvalid_i), .wr_req_i (wr_req),
      .wr_ready_o (wr_ready), .bvalid_o (s_axi_bvalid_o), .bready_i (s_axi_bready_i),
      .rd_valid_i (s_axi_arvalid_i), .rd_req_i (rd_req), .rd_ready_o (s_axi_arready_o),
      .rdata_o (s_axi_rdata_o), .rvalid_o (s_axi_rvalid_o), .rready_i (s_axi_rready_i),
      .ctrl_o (ctrl), .status_i (status), .rx_byte_i (rx_head), .rx_pop_o (rx_pop),
      .tx_byte_o (tx_byte), .tx_push_o (tx_push)
   );

   uart_fifo tx_fifo0 (
      .s_axi_aclk_i, .s_axi_aresetn_i, .push_i (tx_push), .data_i (tx_byte),
      .pop_i (tx_pop), .data_o (tx_head), .full_o (tx_full), .empty_o (tx_empty)
   );

   uart_fifo rx_fifo0 (
      .s_axi_aclk_i, .s_axi_aresetn_i, .push_i (rx_push), .data_i (rx_byte),
      .pop_i (rx_pop), .data_o (rx_head), .full_o (rx_full), .empty_o (rx_empty)
   );

   uart_tx tx0 (
      .s_axi_aclk_i, .s_axi_aresetn_i, .enable_i (ctrl.tx_en), .baud_div_i (ctrl.baud_div),
      .fifo_empty_i (tx_empty), .fifo_data_i (tx_head), .fifo_pop_o (tx_pop),
      .txd_o (uart_txd_o)
   );

   uart_rx rx0 (
      .s_axi_aclk_i, .s_axi_aresetn_i, .enable_i (ctrl.rx_en), .baud_div_i (ctrl.baud_div),
      .rxd_i (uart_rxd_i), .fifo_full_i (rx_full), .fifo_push_o (rx_push),
      .fifo_data_o (rx_byte)
   );

endmodule

// File: tests/axi_uart_tb.sv
`timescale 1ns/1ps

module axi_uart_tb
   import axi_lite_pkg::*;
   import uart_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int FRAME_CYCLES = FRAME_BITS * 8;        // one frame at baud_div 8
   localparam int MAX_CYCLES   = 25 * FRAME_CYCLES * 10; // 20 frames sent, wide margin for bus traffic
   localparam int MAX_POLLS    = 1000;
   localparam int HOLD_CYCLES  = 6;

   localparam axi_addr_t ADDR_CTRL    = UART_BASE_ADDR | axi_addr_t'(REG_CTRL);
   localparam axi_addr_t ADDR_STATUS  = UART_BASE_ADDR | axi_addr_t'(REG_STATUS);
   localparam axi_addr_t ADDR_RDATA   = UART_BASE_ADDR | axi_addr_t'(REG_RDATA);
   localparam axi_addr_t ADDR_WDATA   = UART_BASE_ADDR | axi_addr_t'(REG_WDATA);
   localparam axi_addr_t ADDR_OUTSIDE = 32'h3000_0000; // offset 0 of another window

   localparam axi_data_t CTRL_RUN  = 32'h0008_0003; // div 8, rx and tx on
   localparam axi_data_t CTRL_RX   = 32'h0008_0002;
   localparam axi_data_t CTRL_STOP = 32'h0008_0000;

   localparam uart_status_t ST_IDLE       = 4'hA;
   localparam uart_status_t ST_TX_SOME    = 4'h8;
   localparam uart_status_t ST_TX_FULL    = 4'h9;
   localparam uart_status_t ST_RX_FULL    = 4'h6;
   localparam uart_status_t ST_RX_SOME    = 4'h2;
   localparam uart_status_t MASK_RX_EMPTY = 4'h8;
   localparam uart_status_t MASK_RX_FULL  = 4'h4;

   logic      clk;
   logic      aresetn;
   axi_addr_t awaddr;
   logic      awvalid;
   logic      awready;
   axi_data_t wdata;
   axi_strb_t wstrb;
   logic      wvalid;
   logic      wready;
   logic      bvalid;
   logic      bready;
   axi_addr_t araddr;
   logic      arvalid;
   logic      arready;
   axi_data_t rdata;
   logic      rvalid;
   logic      rready;
   logic      txd;
   logic      rxd;
   int        errors = 0;
   int        cycles = 0;
   uart_byte_t sent_q[$]; // bytes queued in the tx fifo, in order

   assign rxd = txd; // serial loopback

   axi_uart dut0 (
      .s_axi_aclk_i (clk), .s_axi_aresetn_i (aresetn),
      .s_axi_awaddr_i (awaddr), .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready),
      .s_axi_wdata_i (wdata), .s_axi_wstrb_i (wstrb), .s_axi_wvalid_i (wvalid),
      .s_axi_wready_o (wready), .s_axi_bvalid_o (bvalid), .s_axi_bready_i (bready),
      .s_axi_araddr_i (araddr), .s_axi_arvalid_i (arvalid), .s_axi_arready_o (arready),
      .s_axi_rdata_o (rdata), .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready),
      .uart_txd_o (txd), .uart_rxd_i (rxd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      errors++;
   endtask

   task automatic check_data(input string name, input axi_data_t exp, input axi_data_t got);
      if (got !== exp) begin
         $display("MISMATCH %s expected 0x%h got 0x%h", name, exp, got);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input uart_status_t exp,
                               input uart_status_t got);
      if (got !== exp) begin
         $display("MISMATCH %s expected 0x%h got 0x%h", name, exp, got);
         errors++;
      end
   endtask

   task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      @(posedge clk); // aw and w taken on this edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      if (awready || wready) report_error("write ready high while a write response was pending");
      @(posedge clk);
      bready <= 1'b0;
   endtask

   // hold > 0 keeps rready low for that many cycles once rvalid is up
   task automatic axi_read(input axi_addr_t addr, input int hold, output axi_data_t data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= (hold == 0);
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      data = rdata;
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         if (!rvalid) report_error("rvalid dropped while rready was low");
         if (arready) report_error("arready high while a read response was pending");
         check_data("rdata", data, rdata);
      end
      @(posedge clk);
      rready <= 1'b1;
      if (hold > 0) @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic read_status(output uart_status_t st);
      axi_data_t d;
      axi_read(ADDR_STATUS, 0, d);
      st = uart_status_t'(d[3:0]);
   endtask

   task automatic wait_status(input uart_status_t mask, input uart_status_t want,
                              input string what);
      uart_status_t st;
      int           polls;
      polls = 0;
      read_status(st);
      while ((st & mask) != want && polls < MAX_POLLS) begin
         read_status(st);
         polls++;
      end
      if ((st & mask) != want)
         report_error($sformatf("STATUS never showed %s after %0d polls", what, MAX_POLLS));
   endtask

   task automatic reset_state();
      axi_data_t    d;
      uart_status_t st;
      @(negedge clk);
      if (bvalid || rvalid) report_error("bvalid or rvalid high after reset");
      if (awready || wready || arready) report_error("bus ready high in the cycle after reset");
      if (!txd) report_error("serial line not idle high after reset");
      read_status(st);
      check_status("status", ST_IDLE, st);
      axi_read(ADDR_CTRL, 0, d);
      check_data("ctrl", '0, d);
      axi_read(ADDR_OUTSIDE, 0, d); // only has to complete
      axi_write(ADDR_OUTSIDE, CTRL_RUN, 4'hF);
      axi_read(ADDR_CTRL, 0, d);
      check_data("ctrl", '0, d);
   endtask

   task automatic ctrl_lane_writes();
      axi_data_t    d;
      uart_status_t st;
      axi_write(ADDR_CTRL, 32'h1234_0003, 4'b1100); // divider lanes only
      axi_read(ADDR_CTRL, 0, d);
      check_data("ctrl", 32'h1234_0000, d);
      axi_write(ADDR_CTRL, 32'h5678_0002, 4'b0001); // enable lane only
      axi_read(ADDR_CTRL, 0, d);
      check_data("ctrl", 32'h1234_0002, d);
      axi_write(ADDR_STATUS, 32'hFFFF_FFFF, 4'hF);
      read_status(st);
      check_status("status", ST_IDLE, st);
      axi_write(ADDR_RDATA, 32'h0000_00A5, 4'hF);
      read_status(st);
      check_status("status", ST_IDLE, st);
      axi_read(ADDR_RDATA, 0, d);
      check_data("rdata", '0, d);
      axi_write(ADDR_CTRL, '0, 4'hF);
   endtask

   task automatic loopback_bytes();
      axi_data_t    d;
      uart_byte_t   b;
      uart_status_t st;
      axi_write(ADDR_CTRL, CTRL_RUN, 4'hF);
      repeat (4) begin
         b = uart_byte_t'($urandom());
         axi_write(ADDR_WDATA, axi_data_t'(b), 4'b0001);
         wait_status(MASK_RX_EMPTY, 4'h0, "a received byte");
         axi_read(ADDR_RDATA, 0, d);
         check_data("rdata", axi_data_t'(b), d);
         read_status(st);
         check_status("status", ST_IDLE, st);
      end
      axi_write(ADDR_CTRL, CTRL_STOP, 4'hF);
   endtask

   task automatic fill_tx_fifo();
      uart_byte_t   b;
      uart_status_t st;
      sent_q.delete();
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         b = uart_byte_t'($urandom());
         sent_q.push_back(b);
         axi_write(ADDR_WDATA, axi_data_t'(b), 4'b0001);
         if (i == 0) begin
            read_status(st);
            check_status("status", ST_TX_SOME, st);
         end
      end
      read_status(st);
      check_status("status", ST_TX_FULL, st);
      b = uart_byte_t'($urandom());
      axi_write(ADDR_WDATA, axi_data_t'(b), 4'b0001); // fifo full, byte lost
      read_status(st);
      check_status("status", ST_TX_FULL, st);
   endtask

   task automatic receive_until_full();
      uart_status_t st;
      axi_write(ADDR_CTRL, CTRL_RX, 4'hF); // receiver up before the first frame
      axi_write(ADDR_CTRL, CTRL_RUN, 4'hF);
      wait_status(MASK_RX_FULL, MASK_RX_FULL, "rx_full");
      read_status(st);
      check_status("status", ST_RX_FULL, st);
   endtask

   task automatic backpressure_read();
      axi_data_t    d;
      uart_byte_t   b;
      uart_status_t st;
      axi_read(ADDR_RDATA, HOLD_CYCLES, d);
      b = sent_q.pop_front();
      check_data("rdata", axi_data_t'(b), d);
      read_status(st);
      check_status("status", ST_RX_SOME, st);
   endtask

   task automatic drain_rx_fifo();
      axi_data_t    d;
      uart_byte_t   b;
      uart_status_t st;
      while (sent_q.size() > 0) begin
         b = sent_q.pop_front();
         axi_read(ADDR_RDATA, 0, d);
         check_data("rdata", axi_data_t'(b), d);
      end
      axi_read(ADDR_RDATA, 0, d); // the dropped byte must not show up
      check_data("rdata", '0, d);
      read_status(st);
      check_status("status", ST_IDLE, st);
   endtask

   initial begin
      aresetn = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      void'($urandom(62561));
      repeat (4) @(posedge clk);
      aresetn <= 1'b1;
      reset_state();
      ctrl_lane_writes();
      loopback_bytes();
      fill_tx_fifo();
      receive_until_full();
      backpressure_read();
      drain_rx_fifo();
      $display("checks done, %0d errors", errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: axi_uart.f
logic/axi_lite_pkg.sv
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/axi_uart_regs.sv
logic/axi_uart.sv
tests/axi_uart_tb.sv

// File: Makefile
TOP = axi_uart_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f axi_uart.f
	./obj_dir/V$(TOP) | awk '{ print } /^Verification passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module axi_uart -f axi_uart.f

clean:
	rm -rf obj_dir
